/* logic/fetch_pkg.sv */
package fetch_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    // rv32 without compressed instructions
    localparam int unsigned XLEN = 32;
    localparam int unsigned ILEN = 32;

    // ------------------------------
    // instruction memory port
    // ------------------------------
    // req held with a stable word address until the response
    typedef struct packed {
        logic            req;
        logic [XLEN-1:0] addr;
    } imem_req_t;

    // one cycle valid carrying the fetched word
    typedef struct packed {
        logic            valid;
        logic [ILEN-1:0] data;
    } imem_rsp_t;

    // ------------------------------
    // decode side
    // ------------------------------
    // predicted_taken: the next entry's pc came from a prediction
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] instr;
        logic            predicted_taken;
        logic            is_call;
    } fetch_entry_t;

    // control change requests from commit and csr
    typedef struct packed {
        logic            set_pc_commit;
        logic [XLEN-1:0] pc_commit;
        logic            eret;
        logic [XLEN-1:0] epc;
        logic            ex_valid;
        logic [XLEN-1:0] trap_vector_base;
    } redirect_t;

endpackage

/* logic/bpred_pkg.sv */
package bpred_pkg;

    import fetch_pkg::*;

    // ------------------------------
    // control flow classes
    // ------------------------------
    // call and return follow the x1/x5 link register convention
    typedef enum logic [2:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JUMP,
        CF_JALR,
        CF_CALL,
        CF_RETURN
    } cf_e;

    // result of scanning one fetched word
    // imm is sign-extended, B, J or I format depending on cf
    typedef struct packed {
        cf_e             cf;
        logic [XLEN-1:0] imm;
    } scan_t;

    // ------------------------------
    // predictor training and lookup
    // ------------------------------
    // resolved control flow from the execute stage
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            is_branch;
        logic            taken;
        logic            mispredict;
        logic [XLEN-1:0] target;
    } resolved_t;

    // dynamic prediction, only meaningful with valid set
    typedef struct packed {
        logic valid;
        logic taken;
    } bht_pred_t;

    // default sizes, overridden from the top level
    localparam int unsigned BHT_ENTRIES_DEFAULT = 64;
    localparam int unsigned RAS_DEPTH_DEFAULT   = 4;

endpackage

/* logic/instr_scan.sv */
`timescale 1ns/1ns

module instr_scan import fetch_pkg::*, bpred_pkg::*; (
    input  logic [ILEN-1:0] instr_i,
    output scan_t           scan_o
);

    // full 7-bit opcodes, low two bits 11 for rvi
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    logic [6:0]      opcode;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic            rd_link;
    logic            rs1_link;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_i;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];

    // x1 (ra) and x5 (t0) are the link registers
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    // immediates, bit 0 of B and J is implicit zero
    assign imm_b = {{(XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j = {{(XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign imm_i = {{(XLEN-11){instr_i[31]}}, instr_i[30:20]};

    always_comb begin
        scan_o.cf  = CF_NONE;
        scan_o.imm = '0;
        case (opcode)
            OPC_BRANCH: begin
                scan_o.cf  = CF_BRANCH;
                scan_o.imm = imm_b;
            end
            // jal linking into ra/t0 is a call
            OPC_JAL: begin
                scan_o.cf  = rd_link ? CF_CALL : CF_JUMP;
                scan_o.imm = imm_j;
            end
            // jalr through ra/t0 without link is a return
            OPC_JALR: begin
                scan_o.cf  = (rs1_link && rd == 5'd0) ? CF_RETURN : CF_JALR;
                scan_o.imm = imm_i;
            end
            default: ;
        endcase
    end

    // the idle response bus reads as all zeros
    a_rvi_only: assert final ($isunknown(instr_i) || instr_i == '0 || instr_i[1:0] == 2'b11)
        else $error("instr_scan: non 32-bit encoding %h", instr_i);

endmodule

/* logic/bht.sv */
`timescale 1ns/1ns

module bht import fetch_pkg::*, bpred_pkg::*; #(
    parameter int unsigned NrEntries = BHT_ENTRIES_DEFAULT
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    input  logic [XLEN-1:0] pc_i,
    input  resolved_t       update_i,
    output bht_pred_t       pred_o
);

    localparam int unsigned IdxW = $clog2(NrEntries);

    // 00 strong nt, 01 weak nt, 10 weak t, 11 strong t
    logic [1:0]           ctr_q [NrEntries];
    logic [NrEntries-1:0] valid_q;
    logic [IdxW-1:0]      rd_idx;
    logic [IdxW-1:0]      wr_idx;
    logic                 upd_en;

    // word index, bits [1:0] are always zero
    assign rd_idx = pc_i[IdxW+1:2];
    assign wr_idx = update_i.pc[IdxW+1:2];
    assign upd_en = update_i.valid && update_i.is_branch;

    // combinational lookup, msb of the counter is the direction
    assign pred_o.valid = valid_q[rd_idx];
    assign pred_o.taken = ctr_q[rd_idx][1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (upd_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // ------------------------------
    // counter training
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (upd_en) begin
            if (!valid_q[wr_idx]) begin
                // first sighting lands on the weak state of the outcome
                ctr_q[wr_idx] <= update_i.taken ? 2'b10 : 2'b01;
            end else if (update_i.taken && ctr_q[wr_idx] != 2'b11) begin
                ctr_q[wr_idx] <= ctr_q[wr_idx] + 2'b01;
            end else if (!update_i.taken && ctr_q[wr_idx] != 2'b00) begin
                ctr_q[wr_idx] <= ctr_q[wr_idx] - 2'b01;
            end
        end
    end

endmodule

/* logic/ras.sv */
`timescale 1ns/1ns

module ras import fetch_pkg::*; #(
    parameter int unsigned Depth = 4
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    input  logic            push_i,
    input  logic            pop_i,
    input  logic [XLEN-1:0] data_i,
    output logic            top_valid_o,
    output logic [XLEN-1:0] top_o
);

    localparam int unsigned CntW = $clog2(Depth + 1);

    // slot 0 is the top, the oldest entry sits at Depth-1
    logic [XLEN-1:0] stack_q [Depth];
    logic [CntW-1:0] count_q;
    logic            do_pop;

    // popping an empty stack is a no-op
    assign do_pop      = pop_i && (count_q != '0);
    assign top_valid_o = (count_q != '0);
    assign top_o       = stack_q[0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (flush_i) begin
            count_q <= '0;
        end else if (push_i) begin
            // saturate when full, the oldest entry falls off the bottom
            if (count_q != CntW'(Depth)) begin
                count_q <= count_q + 1'b1;
            end
        end else if (do_pop) begin
            count_q <= count_q - 1'b1;
        end
    end

    // shift down on push, up on pop
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            stack_q[0] <= data_i;
            for (int i = 1; i < Depth; i++) begin
                stack_q[i] <= stack_q[i-1];
            end
        end else if (do_pop) begin
            for (int i = 0; i < Depth - 1; i++) begin
                stack_q[i] <= stack_q[i+1];
            end
        end
    end

    // pc_gen never sees a call and a return in the same word
    a_push_pop_excl: assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && pop_i))
        else $error("ras: push and pop in the same cycle");

endmodule

/* logic/pc_gen.sv */
`timescale 1ns/1ns

module pc_gen import fetch_pkg::*, bpred_pkg::*; #(
    parameter logic [XLEN-1:0] BootAddr = 32'h8000_0000
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    output imem_req_t       imem_req_o,
    input  imem_rsp_t       imem_rsp_i,
    input  scan_t           scan_i,
    input  bht_pred_t       bht_i,
    input  logic            ras_valid_i,
    input  logic [XLEN-1:0] ras_top_i,
    input  logic            queue_full_i,
    input  resolved_t       resolved_i,
    input  redirect_t       redirect_i,
    output logic            ras_push_o,
    output logic            ras_pop_o,
    output logic [XLEN-1:0] ras_data_o,
    output fetch_entry_t    push_o,
    output logic            push_valid_o,
    output logic            flush_o,
    output logic [XLEN-1:0] bht_pc_o
);

    // WAIT_KILLED: request still outstanding, its response gets dropped
    typedef enum logic [1:0] {IDLE, WAIT_RSP, WAIT_KILLED} state_e;

    state_e          state_q, state_d;
    logic [XLEN-1:0] npc_q, npc_d;
    logic [XLEN-1:0] addr_q, addr_d;
    logic            started_q;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] cf_target;
    logic [XLEN-1:0] predict_pc;
    logic [XLEN-1:0] redirect_pc;
    logic            predict_taken;
    logic            mispredict;
    logic            redirect_any;
    logic            issue;
    logic            accept;

    // ------------------------------
    // prediction on the returned word
    // ------------------------------
    assign pc_plus4 = addr_q + XLEN'(4);

    always_comb begin
        predict_taken = 1'b0;
        cf_target     = addr_q + scan_i.imm;
        case (scan_i.cf)
            // dynamic if trained, else backward taken
            CF_BRANCH: predict_taken = bht_i.valid ? bht_i.taken : scan_i.imm[XLEN-1];
            CF_JUMP,
            CF_CALL:   predict_taken = 1'b1;
            CF_RETURN: begin
                predict_taken = ras_valid_i;
                cf_target     = ras_top_i;
            end
            // jalr has no target predictor and falls through
            default:   predict_taken = 1'b0;
        endcase
    end

    assign predict_pc = predict_taken ? cf_target : pc_plus4;

    // ------------------------------
    // redirect precedence
    // ------------------------------
    // later assignments win: mispredict < eret < exception < commit flush
    assign mispredict   = resolved_i.valid && resolved_i.mispredict;
    assign redirect_any = mispredict || redirect_i.eret || redirect_i.ex_valid
                       || redirect_i.set_pc_commit;

    always_comb begin
        redirect_pc = resolved_i.target;
        if (redirect_i.eret) begin
            redirect_pc = redirect_i.epc;
        end
        if (redirect_i.ex_valid) begin
            redirect_pc = redirect_i.trap_vector_base;
        end
        // csr side effects resume at the instruction after commit
        if (redirect_i.set_pc_commit) begin
            redirect_pc = redirect_i.pc_commit + XLEN'(4);
        end
    end

    // ------------------------------
    // memory request fsm
    // ------------------------------
    // a new fetch only starts with room in the queue for its word
    assign issue  = (state_q == IDLE) && started_q && !queue_full_i && !redirect_any;
    assign accept = (state_q == WAIT_RSP) && imem_rsp_i.valid && !redirect_any;

    assign imem_req_o.req  = issue || (state_q != IDLE);
    assign imem_req_o.addr = (state_q == IDLE) ? npc_q : addr_q;

    always_comb begin
        state_d = state_q;
        npc_d   = npc_q;
        addr_d  = addr_q;
        case (state_q)
            IDLE: begin
                if (issue) begin
                    state_d = WAIT_RSP;
                    addr_d  = npc_q;
                end
            end
            WAIT_RSP: begin
                if (imem_rsp_i.valid) begin
                    state_d = IDLE;
                    npc_d   = predict_pc;
                end else if (redirect_any) begin
                    state_d = WAIT_KILLED;
                end
            end
            WAIT_KILLED: begin
                if (imem_rsp_i.valid) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
        // back-end redirect overrides any predicted next pc
        if (redirect_any) begin
            npc_d = redirect_pc;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            npc_q     <= BootAddr;
            started_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            npc_q     <= npc_d;
            started_q <= 1'b1;
        end
    end

    // address of the outstanding request
    always_ff @(posedge clk_i) begin
        addr_q <= addr_d;
    end

    // ------------------------------
    // queue, ras and bht side
    // ------------------------------
    assign push_valid_o           = accept;
    assign push_o.pc              = addr_q;
    assign push_o.instr           = imem_rsp_i.data;
    assign push_o.predicted_taken = predict_taken;
    assign push_o.is_call         = (scan_i.cf == CF_CALL);

    assign ras_push_o = accept && (scan_i.cf == CF_CALL);
    assign ras_pop_o  = accept && (scan_i.cf == CF_RETURN) && ras_valid_i;
    assign ras_data_o = pc_plus4;

    assign flush_o  = redirect_any;
    assign bht_pc_o = addr_q;

endmodule

/* logic/fetch_queue.sv */
`timescale 1ns/1ns

module fetch_queue import fetch_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    input  logic         push_valid_i,
    input  fetch_entry_t entry_i,
    output logic         full_o,
    output fetch_entry_t fetch_entry_o,
    output logic         fetch_entry_valid_o,
    input  logic         fetch_entry_ready_i
);

    localparam int unsigned Depth = 4;
    localparam int unsigned PtrW  = $clog2(Depth);

    fetch_entry_t    mem_q [Depth];
    logic [PtrW-1:0] rd_ptr_q;
    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW:0]   count_q;
    logic            do_push;
    logic            do_pop;

    assign do_push = push_valid_i && !full_o;
    assign do_pop  = fetch_entry_valid_o && fetch_entry_ready_i;

    assign full_o              = (count_q == (PtrW+1)'(Depth));
    assign fetch_entry_valid_o = (count_q != '0);
    // head read straight from the storage flops
    assign fetch_entry_o       = mem_q[rd_ptr_q];

    // ------------------------------
    // pointers and fill level
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // redirect drops everything queued
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    // pc_gen only requests with a free slot
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_valid_i |-> !full_o)
        else $error("fetch_queue: push while full");

    // valid/ready, the head holds until taken or flushed
    a_head_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_entry_valid_o && !fetch_entry_ready_i && !flush_i
        |=> fetch_entry_valid_o && $stable(fetch_entry_o))
        else $error("fetch_queue: head changed under back-pressure");

endmodule

/* logic/fetch_frontend.sv */
`timescale 1ns/1ns

module fetch_frontend import fetch_pkg::*, bpred_pkg::*; #(
    parameter int unsigned     NrBhtEntries = BHT_ENTRIES_DEFAULT,
    parameter int unsigned     RasDepth     = RAS_DEPTH_DEFAULT,
    parameter logic [XLEN-1:0] BootAddr     = 32'h8000_0000
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_bp_i,
    input  resolved_t    resolved_branch_i,
    input  redirect_t    redirect_i,
    output imem_req_t    imem_req_o,
    input  imem_rsp_t    imem_rsp_i,
    output fetch_entry_t fetch_entry_o,
    output logic         fetch_entry_valid_o,
    input  logic         fetch_entry_ready_i
);

    scan_t           scan;
    bht_pred_t       bht_pred;
    logic [XLEN-1:0] bht_pc;
    logic            ras_valid;
    logic [XLEN-1:0] ras_top;
    logic            ras_push;
    logic            ras_pop;
    logic [XLEN-1:0] ras_data;
    logic            queue_full;
    fetch_entry_t    push_entry;
    logic            push_valid;
    logic            queue_flush;

    // ------------------------------
    // predictors
    // ------------------------------
    // scan the response word as it arrives
    instr_scan i_instr_scan (
        .instr_i ( imem_rsp_i.data ),
        .scan_o  ( scan            )
    );

    // trained directly by the resolved branch
    bht #(
        .NrEntries ( NrBhtEntries )
    ) i_bht (
        .clk_i    ( clk_i             ),
        .rst_ni   ( rst_ni            ),
        .flush_i  ( flush_bp_i        ),
        .pc_i     ( bht_pc            ),
        .update_i ( resolved_branch_i ),
        .pred_o   ( bht_pred          )
    );

    ras #(
        .Depth ( RasDepth )
    ) i_ras (
        .clk_i       ( clk_i      ),
        .rst_ni      ( rst_ni     ),
        .flush_i     ( flush_bp_i ),
        .push_i      ( ras_push   ),
        .pop_i       ( ras_pop    ),
        .data_i      ( ras_data   ),
        .top_valid_o ( ras_valid  ),
        .top_o       ( ras_top    )
    );

    // ------------------------------
    // next pc and request
    // ------------------------------
    pc_gen #(
        .BootAddr ( BootAddr )
    ) i_pc_gen (
        .clk_i        ( clk_i             ),
        .rst_ni       ( rst_ni            ),
        .imem_req_o   ( imem_req_o        ),
        .imem_rsp_i   ( imem_rsp_i        ),
        .scan_i       ( scan              ),
        .bht_i        ( bht_pred          ),
        .ras_valid_i  ( ras_valid         ),
        .ras_top_i    ( ras_top           ),
        .queue_full_i ( queue_full        ),
        .resolved_i   ( resolved_branch_i ),
        .redirect_i   ( redirect_i        ),
        .ras_push_o   ( ras_push          ),
        .ras_pop_o    ( ras_pop           ),
        .ras_data_o   ( ras_data          ),
        .push_o       ( push_entry        ),
        .push_valid_o ( push_valid        ),
        .flush_o      ( queue_flush       ),
        .bht_pc_o     ( bht_pc            )
    );

    // toward decode
    fetch_queue i_fetch_queue (
        .clk_i               ( clk_i               ),
        .rst_ni              ( rst_ni              ),
        .flush_i             ( queue_flush         ),
        .push_valid_i        ( push_valid          ),
        .entry_i             ( push_entry          ),
        .full_o              ( queue_full          ),
        .fetch_entry_o       ( fetch_entry_o       ),
        .fetch_entry_valid_o ( fetch_entry_valid_o ),
        .fetch_entry_ready_i ( fetch_entry_ready_i )
    );

endmodule

/* verification/tb_fetch_frontend.sv */
`timescale 1ns/1ns

module tb_fetch_frontend import fetch_pkg::*, bpred_pkg::*; ;

    logic         clk_i;
    logic         rst_ni;
    logic         flush_bp;
    resolved_t    resolved;
    redirect_t    redirect;
    imem_req_t    imem_req;
    imem_rsp_t    imem_rsp;
    fetch_entry_t entry;
    logic         entry_valid;
    logic         entry_ready;

    // memory image window 0x8000_0000 .. 0x8000_0fff
    logic [31:0]      mem [1024];
    logic             loaded [1024];
    logic             rsp_pending;
    logic [31:0]      rsp_addr;
    int unsigned      rsp_delay;

    logic [8*32-1:0]  test_name;
    logic [8*32-1:0]  key;
    logic             in_test;
    logic             aborted;
    int               test_errs;
    int               tests_run;
    int               tests_bad;
    int               checks;
    int               mismatches;

    fetch_frontend i_fetch_frontend (
        .clk_i               ( clk_i       ),
        .rst_ni              ( rst_ni      ),
        .flush_bp_i          ( flush_bp    ),
        .resolved_branch_i   ( resolved    ),
        .redirect_i          ( redirect    ),
        .imem_req_o          ( imem_req    ),
        .imem_rsp_i          ( imem_rsp    ),
        .fetch_entry_o       ( entry       ),
        .fetch_entry_valid_o ( entry_valid ),
        .fetch_entry_ready_i ( entry_ready )
    );

    // 40 ns period
    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    // ------------------------------
    // memory model
    // ------------------------------
    // unloaded words read as op-imm and never change control flow
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] fill;
        fill = {addr[31:7] ^ {addr[6:0], addr[31:14]}, 7'b0010011};
        if (addr[31:12] == 20'h80000 && loaded[addr[11:2]]) begin
            return mem[addr[11:2]];
        end else begin
            return fill;
        end
    endfunction

    // a new request is never taken in the cycle of a response
    always @(negedge clk_i) begin
        if (rst_ni && rsp_pending) begin
            // the outstanding request holds req and addr until answered
            check_value("req", 32'd1, 32'(imem_req.req));
            check_value("addr", rsp_addr, imem_req.addr);
        end else if (rst_ni && !imem_rsp.valid && imem_req.req) begin
            rsp_pending = 1'b1;
            rsp_addr    = imem_req.addr;
            rsp_delay   = 1 + ($urandom % 3);
        end
    end

    always @(posedge clk_i) begin
        #2;
        imem_rsp.valid = 1'b0;
        imem_rsp.data  = '0;
        if (rsp_pending) begin
            rsp_delay = rsp_delay - 1;
            if (rsp_delay == 0) begin
                imem_rsp.valid = 1'b1;
                imem_rsp.data  = read_word(rsp_addr);
                rsp_pending    = 1'b0;
            end
        end
    end

    // ------------------------------
    // checks and stimulus
    // ------------------------------
    task automatic check_value(input logic [8*32-1:0] what, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        checks++;
        if (exp_val !== act_val) begin
            test_errs++;
            $display("FAILED %0s %0s: expected %h, actual %h", test_name, what, exp_val, act_val);
        end
    endtask

    // jal that links into ra or t0
    function automatic logic is_call_word(input logic [31:0] instr);
        logic link_rd;
        link_rd = (instr[11:7] == 5'd1) || (instr[11:7] == 5'd5);
        return (instr[6:0] == 7'b1101111) && link_rd;
    endfunction

    // pop one entry with random decode back-pressure
    task automatic expect_entry(input logic [31:0] pc, input logic [31:0] instr,
                                input logic pt);
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < 200) begin
            entry_ready = ($urandom % 4) != 0;
            @(negedge clk_i);
            if (entry_valid && entry_ready) begin
                got = 1'b1;
                check_value("pc", pc, entry.pc);
                check_value("instr", instr, entry.instr);
                check_value("predicted_taken", 32'(pt), 32'(entry.predicted_taken));
                check_value("is_call", 32'(is_call_word(instr)), 32'(entry.is_call));
            end
            @(posedge clk_i);
            #2;
            cycles++;
        end
        entry_ready = 1'b0;
        if (!got) begin
            $display("ERROR: test %0s waited 200 cycles and no entry reached decode", test_name);
            aborted = 1'b1;
        end
    endtask

    task automatic pulse_flush_bp();
        flush_bp = 1'b1;
        @(posedge clk_i);
        #2;
        flush_bp = 1'b0;
    endtask

    // trains the bht without a mispredict
    task automatic apply_resolve(input logic [31:0] pc, input logic taken);
        resolved           = '0;
        resolved.valid     = 1'b1;
        resolved.pc        = pc;
        resolved.is_branch = 1'b1;
        resolved.taken     = taken;
        @(posedge clk_i);
        #2;
        resolved = '0;
    endtask

    // mask bit 0 mispredict, bit 1 eret, bit 2 exception, bit 3 commit flush
    task automatic apply_redirect(input logic [3:0] mask, input logic [31:0] mis_pc,
                                  input logic [31:0] epc, input logic [31:0] tvec,
                                  input logic [31:0] commit_pc);
        resolved                  = '0;
        resolved.valid            = mask[0];
        resolved.mispredict       = mask[0];
        resolved.target           = mis_pc;
        redirect.eret             = mask[1];
        redirect.epc              = epc;
        redirect.ex_valid         = mask[2];
        redirect.trap_vector_base = tvec;
        redirect.set_pc_commit    = mask[3];
        redirect.pc_commit        = commit_pc;
        @(posedge clk_i);
        #2;
        resolved = '0;
        redirect = '0;
    endtask

    task automatic close_test();
        if (in_test) begin
            tests_run++;
            mismatches += test_errs;
            if (test_errs == 0) begin
                $display("test %0s: ok", test_name);
            end else begin
                tests_bad++;
                $display("test %0s: %0d mismatches", test_name, test_errs);
            end
        end
        test_errs = 0;
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int          fd;
        int          c;
        logic [31:0] a0, a1, a2, a3, a4;
        void'($urandom(40));
        rst_ni      = 1'b0;
        flush_bp    = 1'b0;
        resolved    = '0;
        redirect    = '0;
        imem_rsp    = '0;
        entry_ready = 1'b0;
        rsp_pending = 1'b0;
        in_test     = 1'b0;
        aborted     = 1'b0;
        test_errs   = 0;
        tests_run   = 0;
        tests_bad   = 0;
        checks      = 0;
        mismatches  = 0;
        for (int i = 0; i < 1024; i++) begin
            loaded[i] = 1'b0;
        end
        repeat (5) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        fd = $fopen("verification/fetch_testdata.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the test data file could not be opened");
            aborted = 1'b1;
        end else begin
            while (!aborted && $fscanf(fd, "%s", key) == 1) begin
                if (key == "#") begin
                    c = 0;
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (key == "M") begin
                    void'($fscanf(fd, "%h %h", a0, a1));
                    mem[a0[11:2]]    = a1;
                    loaded[a0[11:2]] = 1'b1;
                end else if (key == "T") begin
                    close_test();
                    void'($fscanf(fd, "%s", test_name));
                    in_test = 1'b1;
                end else if (key == "F") begin
                    pulse_flush_bp();
                end else if (key == "U") begin
                    void'($fscanf(fd, "%h %h", a0, a1));
                    apply_resolve(a0, a1[0]);
                end else if (key == "X") begin
                    void'($fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4));
                    apply_redirect(a0[3:0], a1, a2, a3, a4);
                end else if (key == "E") begin
                    void'($fscanf(fd, "%h %h %h", a0, a1, a2));
                    expect_entry(a0, a1, a2[0]);
                end else begin
                    $display("ERROR: unknown command %0s in the test data file", key);
                    aborted = 1'b1;
                end
            end
            $fclose(fd);
            close_test();
        end
        $display("tests %0d, failing tests %0d, checks %0d, mismatches %0d",
                 tests_run, tests_bad, checks, mismatches);
        if (!aborted && mismatches == 0 && tests_run > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
logic/fetch_pkg.sv
logic/bpred_pkg.sv
logic/instr_scan.sv
logic/bht.sv
logic/ras.sv
logic/pc_gen.sv
logic/fetch_queue.sv
logic/fetch_frontend.sv
verification/tb_fetch_frontend.sv

/* verification/fetch_testdata.txt */
# M addr word | T name | F flush_bp | U pc taken | E pc instr predicted_taken
# X mask mispredict_target epc trap_vector pc_commit (mask 1 mis, 2 eret, 4 ex, 8 commit)
M 80000000 00100093
M 80000004 00200113
M 80000008 00300193
M 8000000c 00400213
M 80000010 0200006f
M 80000030 00500293
M 80000100 00600313
M 80000104 fe000ee3
M 80000108 00001463
M 8000010c 00700393
M 80000110 00800413
M 80000200 040000ef
M 80000204 00900493
M 80000240 00008067
M 80000244 00a00513
M 80000300 00b00593
M 80000310 00c00613
M 80000320 00d00693
M 80000330 00e00713
T boot_seq
E 80000000 00100093 0
E 80000004 00200113 0
E 80000008 00300193 0
E 8000000c 00400213 0
T jal_target
E 80000010 0200006f 1
E 80000030 00500293 0
T static_branch
F
X 8 0 0 0 800000fc
E 80000100 00600313 0
E 80000104 fe000ee3 1
E 80000100 00600313 0
X 8 0 0 0 80000104
E 80000108 00001463 0
E 8000010c 00700393 0
T bht_training
U 80000108 1
X 8 0 0 0 80000104
E 80000108 00001463 1
E 80000110 00800413 0
U 80000108 0
U 80000108 0
X 8 0 0 0 80000104
E 80000108 00001463 0
E 8000010c 00700393 0
T call_return
F
X 8 0 0 0 800001fc
E 80000200 040000ef 1
E 80000240 00008067 1
E 80000204 00900493 0
X 8 0 0 0 8000023c
E 80000240 00008067 0
E 80000244 00a00513 0
T redirect_precedence
X 1 80000300 80000310 80000320 8000032c
E 80000300 00b00593 0
X 3 80000300 80000310 80000320 8000032c
E 80000310 00c00613 0
X 7 80000300 80000310 80000320 8000032c
E 80000320 00d00693 0
X f 80000300 80000310 80000320 8000032c
E 80000330 00e00713 0
X 6 80000300 80000310 80000320 8000032c
E 80000320 00d00693 0
